// ==== sources.f ====
hdl/xlat_pkg.sv
hdl/request_decode.sv
hdl/burst_beat_tracker.sv
hdl/burst_address_gen.sv
hdl/master_translator.sv
tests/tb_clock.sv
tests/tb_master_translator.sv

// ==== Makefile ====
TOP := tb_master_translator

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f sources.f --top-module $(TOP) -o sim

# pass only when the testbench printed its pass line
run: compile
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

// ==== tests/tb_master_translator.sv ====
`default_nettype none

module tb_master_translator import xlat_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   // longest stall the slave model inserts before it accepts a beat
   localparam int MAX_STALL     = 3;
   // request beats and read data cycles of all tests: 5 + 7 + 9 + 32 + 14
   localparam int TOTAL_BEATS   = 67;
   localparam int MARGIN_CYCLES = 100;

   logic        clk;
   logic        reset;
   logic        av_read;
   logic        av_write;
   word_addr_t  av_address;
   word_count_t av_burstcount;
   data_t       av_writedata;
   byte_en_t    av_byteenable;
   data_t       av_readdata;
   logic        av_readdatavalid;
   logic        av_waitrequest;
   logic        uav_read;
   logic        uav_write;
   byte_addr_t  uav_address;
   byte_count_t uav_burstcount;
   data_t       uav_writedata;
   byte_en_t    uav_byteenable;
   data_t       uav_readdata;
   logic        uav_readdatavalid;
   logic        uav_waitrequest;

   int     errors = 0;
   integer seed   = 93;

   tb_clock i_tb_clock (.clk(clk));

   master_translator i_master_translator (.*);

   task automatic report_mismatch(input string test, input string field,
                                  input logic [31:0] expected, input logic [31:0] actual);
      errors++;
      $display("[FAIL] %s: %s expected %h, actual %h at %0t", test, field, expected, actual,
               $time);
   endtask

   // ------------------------------------------------------------------------
   // master and slave model
   // ------------------------------------------------------------------------

   // one beat held through its stall cycles, outputs checked mid cycle
   task automatic send_beat(input string test, input logic write, input word_addr_t addr,
                            input word_count_t count, input int stalls,
                            input byte_addr_t exp_addr, input byte_count_t exp_count);
      data_t    data;
      byte_en_t be;
      logic     read;
      logic     stall;
      data = $random(seed);
      be   = byte_en_t'($random(seed));
      read = ~write;
      for (int s = 0; s <= stalls; s++) begin
         stall = (s < stalls);
         @(posedge clk);
         av_read           <= read;
         av_write          <= write;
         av_address        <= addr;
         av_burstcount     <= count;
         av_writedata      <= data;
         av_byteenable     <= be;
         uav_waitrequest   <= stall;
         uav_readdatavalid <= 1'b0;
         @(negedge clk);
         if (uav_read !== read) report_mismatch(test, "uav_read", 32'(read), 32'(uav_read));
         if (uav_write !== write) report_mismatch(test, "uav_write", 32'(write), 32'(uav_write));
         if (uav_address !== exp_addr)
            report_mismatch(test, "uav_address", 32'(exp_addr), 32'(uav_address));
         if (uav_burstcount !== exp_count)
            report_mismatch(test, "uav_burstcount", 32'(exp_count), 32'(uav_burstcount));
         if (av_waitrequest !== stall)
            report_mismatch(test, "av_waitrequest", 32'(stall), 32'(av_waitrequest));
         if (uav_writedata !== data) report_mismatch(test, "uav_writedata", data, uav_writedata);
         if (uav_byteenable !== be)
            report_mismatch(test, "uav_byteenable", 32'(be), 32'(uav_byteenable));
      end
   endtask

   // n beat write burst from word address addr, only the first send beats go out
   task automatic write_burst(input string test, input word_addr_t addr, input int n,
                              input int send, input bit stalled);
      int stalls;
      for (int k = 0; k < send; k++) begin
         stalls = stalled ? ($random(seed) & MAX_STALL) : 0;
         send_beat(test, 1'b1, addr, word_count_t'(n), stalls,
                   byte_addr_t'(4 * addr + 4 * k), byte_count_t'(4 * (n - k)));
      end
   endtask

   task automatic read_burst(input string test, input word_addr_t addr, input int n,
                             input int stalls);
      data_t data;
      send_beat(test, 1'b0, addr, word_count_t'(n), stalls,
                byte_addr_t'(4 * addr), byte_count_t'(4 * n));
      // slave returns n words, the master sees each one in the same cycle
      for (int k = 0; k < n; k++) begin
         data = $random(seed);
         @(posedge clk);
         av_read           <= 1'b0;
         av_write          <= 1'b0;
         uav_waitrequest   <= 1'b0;
         uav_readdata      <= data;
         uav_readdatavalid <= 1'b1;
         @(negedge clk);
         if (av_readdatavalid !== 1'b1)
            report_mismatch(test, "av_readdatavalid", 1, 32'(av_readdatavalid));
         if (av_readdata !== data) report_mismatch(test, "av_readdata", data, av_readdata);
      end
   endtask

   task automatic go_idle(input string test, input int cycles);
      for (int c = 0; c < cycles; c++) begin
         @(posedge clk);
         av_read           <= 1'b0;
         av_write          <= 1'b0;
         uav_waitrequest   <= 1'b0;
         uav_readdatavalid <= 1'b0;
         @(negedge clk);
         if (uav_read !== 1'b0) report_mismatch(test, "uav_read", 0, 32'(uav_read));
         if (uav_write !== 1'b0) report_mismatch(test, "uav_write", 0, 32'(uav_write));
         if (av_readdatavalid !== 1'b0)
            report_mismatch(test, "av_readdatavalid", 0, 32'(av_readdatavalid));
      end
   endtask

   // ------------------------------------------------------------------------
   // directed tests
   // ------------------------------------------------------------------------
   task automatic test_after_reset();
      go_idle("after_reset", 2);
      // reset in the middle of a burst, the next write must start clean
      write_burst("after_reset", 16'h0100, 4, 2, 1'b0);
      @(posedge clk);
      reset           <= 1'b1;
      av_write        <= 1'b0;
      uav_waitrequest <= 1'b0;
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      go_idle("after_reset", 1);
      write_burst("after_reset", 16'h0200, 3, 3, 1'b0);
      go_idle("after_reset", 1);
   endtask

   task automatic test_single_read();
      read_burst("single_read", 16'h0040, 4, 2);
      read_burst("single_read", 16'h3fff, 1, 0);
      go_idle("single_read", 1);
   endtask

   task automatic test_write_burst();
      write_burst("write_burst", 16'h1000, 8, 8, 1'b0);
      go_idle("write_burst", 1);
      write_burst("write_burst", 16'hffff, 1, 1, 1'b0);
      go_idle("write_burst", 1);
   endtask

   task automatic test_write_stalls();
      int         n;
      word_addr_t addr;
      for (int i = 0; i < 4; i++) begin
         n    = 1 + ($random(seed) & 7);
         addr = word_addr_t'($random(seed));
         write_burst("write_stalls", addr, n, n, 1'b1);
         go_idle("write_stalls", 1);
      end
   endtask

   task automatic test_back_to_back();
      write_burst("back_to_back", 16'h2000, 5, 5, 1'b1);
      read_burst("back_to_back", 16'h3000, 2, 1);
      write_burst("back_to_back", 16'h0abc, 6, 6, 1'b1);
      go_idle("back_to_back", 2);
   endtask

   // ------------------------------------------------------------------------
   // main sequence and watchdog
   // ------------------------------------------------------------------------
   initial begin
      reset             = 1'b1;
      av_read           = 1'b0;
      av_write          = 1'b0;
      av_address        = '0;
      av_burstcount     = '0;
      av_writedata      = '0;
      av_byteenable     = '0;
      uav_readdata      = '0;
      uav_readdatavalid = 1'b0;
      uav_waitrequest   = 1'b0;
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      test_after_reset();
      test_single_read();
      test_write_burst();
      test_write_stalls();
      test_back_to_back();
      $display("summary: 5 tests run, %0d errors", errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

   initial begin
      #((TOTAL_BEATS * (MAX_STALL + 1) + MARGIN_CYCLES) * 4);
      $display("watchdog expired: the tests did not finish in time");
      $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`default_nettype none

module tb_clock (
   output logic clk
);

   timeunit 1ns;
   timeprecision 100ps;

   // free running clock, 4 ns period
   initial begin
      clk = 1'b0;
      forever begin
         #2 clk = ~clk;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/master_translator.sv ====
`default_nettype none

module master_translator import xlat_pkg::*; (
   input  wire              clk,
   input  wire              reset,

   // word addressed master
   input  wire              av_read,
   input  wire              av_write,
   input  wire word_addr_t  av_address,
   input  wire word_count_t av_burstcount,
   input  wire data_t       av_writedata,
   input  wire byte_en_t    av_byteenable,
   output data_t            av_readdata,
   output logic             av_readdatavalid,
   output logic             av_waitrequest,

   // byte addressed universal master
   output logic             uav_read,
   output logic             uav_write,
   output byte_addr_t       uav_address,
   output byte_count_t      uav_burstcount,
   output data_t            uav_writedata,
   output byte_en_t         uav_byteenable,
   input  wire data_t       uav_readdata,
   input  wire              uav_readdatavalid,
   input  wire              uav_waitrequest
);

   logic        begin_transfer;
   logic        begin_burst;
   byte_addr_t  addr_scaled;
   word_count_t beats_scaled;
   word_count_t beats_left;

   // ------------------------------------------------------------------------
   // pass-through paths, zero latency
   // ------------------------------------------------------------------------
   assign uav_read         = av_read;
   assign uav_write        = av_write;
   assign uav_writedata    = av_writedata;
   assign uav_byteenable   = av_byteenable;
   assign av_readdata      = uav_readdata;
   assign av_readdatavalid = uav_readdatavalid;
   assign av_waitrequest   = uav_waitrequest;

   // ------------------------------------------------------------------------
   // stage chain: decode, beat tracking, address generation
   // ------------------------------------------------------------------------
   request_decode i_request_decode (
      .clk             (clk),
      .reset           (reset),
      .av_read         (av_read),
      .av_write        (av_write),
      .av_address      (av_address),
      .av_burstcount   (av_burstcount),
      .uav_waitrequest (uav_waitrequest),
      .begin_transfer  (begin_transfer),
      .addr_scaled     (addr_scaled),
      .beats_scaled    (beats_scaled)
   );

   burst_beat_tracker i_burst_beat_tracker (
      .clk             (clk),
      .reset           (reset),
      .av_read         (av_read),
      .av_write        (av_write),
      .begin_transfer  (begin_transfer),
      .beats_scaled    (beats_scaled),
      .uav_waitrequest (uav_waitrequest),
      .begin_burst     (begin_burst),
      .beats_left      (beats_left)
   );

   burst_address_gen i_burst_address_gen (
      .clk             (clk),
      .reset           (reset),
      .av_write        (av_write),
      .uav_waitrequest (uav_waitrequest),
      .begin_burst     (begin_burst),
      .addr_scaled     (addr_scaled),
      .beats_scaled    (beats_scaled),
      .beats_left      (beats_left),
      .uav_address     (uav_address),
      .uav_burstcount  (uav_burstcount)
   );

endmodule

`default_nettype wire

// ==== hdl/burst_address_gen.sv ====
`default_nettype none

module burst_address_gen import xlat_pkg::*; (
   input  wire              clk,
   input  wire              reset,
   input  wire              av_write,
   input  wire              uav_waitrequest,
   input  wire              begin_burst,
   input  wire byte_addr_t  addr_scaled,
   input  wire word_count_t beats_scaled,
   input  wire word_count_t beats_left,
   output byte_addr_t       uav_address,
   output byte_count_t      uav_burstcount
);

   // byte address of the beat after the one last accepted
   byte_addr_t address_reg;
   byte_addr_t address_now;

   // ------------------------------------------------------------------------
   // outgoing address and count
   // ------------------------------------------------------------------------
   assign address_now = begin_burst ? addr_scaled : address_reg;

   always_comb begin
      if (begin_burst) begin
         uav_address    = addr_scaled;
         uav_burstcount = {beats_scaled, {BYTE_SHIFT{1'b0}}};
      end else begin
         uav_address    = address_reg;
         uav_burstcount = {beats_left, {BYTE_SHIFT{1'b0}}};
      end
   end

   // ------------------------------------------------------------------------
   // next beat address
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         address_reg <= '0;
      end else if (uav_waitrequest) begin
         // hold the stalled beat's address for the following cycles
         address_reg <= address_now;
      end else if (av_write) begin
         address_reg <= address_now + byte_addr_t'(BYTES_PER_WORD);
      end
   end

   // every generated address stays word aligned
   a_word_aligned : assert property (
      @(posedge clk) disable iff (reset)
      uav_address[BYTE_SHIFT-1:0] == '0
   ) else $error("uav_address not word aligned: %h", uav_address);

endmodule

`default_nettype wire

// ==== hdl/burst_beat_tracker.sv ====
`default_nettype none

module burst_beat_tracker import xlat_pkg::*; (
   input  wire              clk,
   input  wire              reset,
   input  wire              av_read,
   input  wire              av_write,
   input  wire              begin_transfer,
   input  wire word_count_t beats_scaled,
   input  wire              uav_waitrequest,
   output logic             begin_burst,
   output word_count_t      beats_left
);

   // a write burst is in progress, later beats are not a burst start
   logic burst_open;
   // the first beat of a burst is stalled
   logic first_stalled;
   // a later beat of the burst is stalled
   logic beat_stalled;
   logic last_beat;

   // ------------------------------------------------------------------------
   // begin of burst
   // ------------------------------------------------------------------------

   // every read is a burst of its own
   assign begin_burst = av_read ? begin_transfer : (begin_transfer & ~burst_open);

   // on the first beat the count comes straight from the master
   assign last_beat = begin_burst ? (beats_scaled == word_count_t'(1))
                                  : (beats_left == word_count_t'(1));

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         burst_open <= 1'b0;
      end else begin
         if ((last_beat && begin_transfer) || av_read) begin
            burst_open <= 1'b0;
         end else if (av_write && begin_transfer) begin
            burst_open <= 1'b1;
         end
      end
   end

   // ------------------------------------------------------------------------
   // beats remaining
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         first_stalled <= 1'b0;
         beat_stalled  <= 1'b0;
         beats_left    <= '0;
      end else begin
         if (begin_burst || first_stalled) begin
            first_stalled <= uav_waitrequest;
            if (uav_waitrequest) begin
               // keep the full length visible while the first beat waits
               beats_left <= beats_scaled;
            end else begin
               beats_left <= beats_scaled - word_count_t'(1);
            end
         end else if (begin_transfer || beat_stalled) begin
            beat_stalled <= uav_waitrequest;
            if (!uav_waitrequest) begin
               beats_left <= beats_left - word_count_t'(1);
            end
         end
      end
   end

   // ------------------------------------------------------------------------
   // a later write beat only exists while the counter says beats remain
   // ------------------------------------------------------------------------
   property p_beats_remain;
      @(posedge clk) disable iff (reset)
      (av_write && !begin_burst && !uav_waitrequest) |-> (beats_left != '0);
   endproperty

   a_beats_remain : assert property (p_beats_remain)
      else $error("write beat accepted with no beats left in the burst");

endmodule

`default_nettype wire

// ==== hdl/request_decode.sv ====
`default_nettype none

module request_decode import xlat_pkg::*; (
   input  wire              clk,
   input  wire              reset,
   input  wire              av_read,
   input  wire              av_write,
   input  wire word_addr_t  av_address,
   input  wire word_count_t av_burstcount,
   input  wire              uav_waitrequest,
   output logic             begin_transfer,
   output byte_addr_t       addr_scaled,
   output word_count_t      beats_scaled
);

   logic request;
   // set once the current beat has been seen, until it is accepted
   logic transfer_started;

   // ------------------------------------------------------------------------
   // address and count scaling
   // ------------------------------------------------------------------------

   // word address to byte address, low byte lane bits are zero
   assign addr_scaled  = {av_address, {BYTE_SHIFT{1'b0}}};

   // count stays in beats here, the byte scaling happens at the output mux
   assign beats_scaled = av_burstcount;

   // ------------------------------------------------------------------------
   // begin of transfer
   // ------------------------------------------------------------------------
   assign request        = av_read | av_write;
   assign begin_transfer = request & ~transfer_started;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         transfer_started <= 1'b0;
      end else begin
         if (begin_transfer && uav_waitrequest) begin
            transfer_started <= 1'b1;
         end else if (uav_waitrequest) begin
            transfer_started <= transfer_started;
         end else begin
            // beat accepted or idle, next request is a fresh beat
            transfer_started <= 1'b0;
         end
      end
   end

   // ------------------------------------------------------------------------
   // master must hold its request while the slave stalls it
   // ------------------------------------------------------------------------
   property p_request_held;
      @(posedge clk) disable iff (reset)
      (request && uav_waitrequest) |=>
         $stable(av_read) && $stable(av_write) &&
         $stable(av_address) && $stable(av_burstcount);
   endproperty

   a_request_held : assert property (p_request_held)
      else $error("master changed its request while waitrequest was high");

endmodule

`default_nettype wire

// ==== hdl/xlat_pkg.sv ====
`default_nettype none

package xlat_pkg;

   // ------------------------------------------------------------------------
   // master side widths
   // ------------------------------------------------------------------------
   localparam int AV_ADDRESS_W     = 16;
   localparam int AV_DATA_W        = 32;
   localparam int AV_BURSTCOUNT_W  = 4;

   // byte lanes per word, and the shift from word to byte units
   localparam int BYTES_PER_WORD   = 4;
   localparam int BYTE_SHIFT       = 2;

   // universal side carries the same range in bytes
   localparam int UAV_ADDRESS_W    = AV_ADDRESS_W + BYTE_SHIFT;
   localparam int UAV_BURSTCOUNT_W = AV_BURSTCOUNT_W + BYTE_SHIFT;

   typedef logic [AV_ADDRESS_W-1:0]     word_addr_t;
   typedef logic [UAV_ADDRESS_W-1:0]    byte_addr_t;
   // beats in a burst, also used for the beats still to go
   typedef logic [AV_BURSTCOUNT_W-1:0]  word_count_t;
   typedef logic [UAV_BURSTCOUNT_W-1:0] byte_count_t;
   typedef logic [AV_DATA_W-1:0]        data_t;
   typedef logic [BYTES_PER_WORD-1:0]   byte_en_t;

endpackage

`default_nettype wire
